// File: rtl/sram_axi_config.svh
`ifndef SRAM_AXI_CONFIG_SVH
`define SRAM_AXI_CONFIG_SVH

// One 8-byte word per beat
`define SRAM_DATA_W    64
`define SRAM_STRB_W    8

// Byte address and memory depth
`define SRAM_ADDR_W    11
`define SRAM_DEPTH     256
`define SRAM_WORD_LSB  3

// AXI fields
`define AXI_ID_W       4
`define AXI_LEN_W      8
`define SRAM_MAX_BEATS 16

`endif

// File: rtl/sram_axi_pkg.sv
`default_nettype none

package sram_axi_pkg;

    // Controller states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RD_DATA = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3
    } state_e;

    // AXI burst encodings
    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } resp_e;

endpackage

`default_nettype wire

// File: rtl/burst_if.sv
`default_nettype none
`include "sram_axi_config.svh"

interface burst_if;

    // Burst setup from the controller
    logic                                     load;
    logic [`SRAM_ADDR_W-`SRAM_WORD_LSB-1:0]   start_addr;
    logic [`AXI_LEN_W-1:0]                    len;
    sram_axi_pkg::burst_e                     burst;
    logic                                     step;

    // Current beat back from the generator
    logic [`SRAM_ADDR_W-`SRAM_WORD_LSB-1:0]   addr;
    logic                                     last;

    modport ctrl (output load, start_addr, len, burst, step, input addr, last);
    modport gen  (input load, start_addr, len, burst, step, output addr, last);

endinterface

`default_nettype wire

// File: rtl/axi_slave_fsm.sv
`default_nettype none
`include "sram_axi_config.svh"

module axi_slave_fsm (
    input  wire logic                                   i_aclk,
    input  wire logic                                   i_areset_n,
    // Read address
    input  wire logic [`AXI_ID_W-1:0]                   i_arid,
    input  wire logic [`SRAM_ADDR_W-`SRAM_WORD_LSB-1:0] i_araddr,
    input  wire logic [`AXI_LEN_W-1:0]                  i_arlen,
    input  wire logic [1:0]                             i_arburst,
    input  wire logic                                   i_arvalid,
    output logic                                        o_arready,
    // Read data
    input  wire logic                                   i_rready,
    output logic [`AXI_ID_W-1:0]                        o_rid,
    output logic [1:0]                                  o_rresp,
    output logic                                        o_rlast,
    output logic                                        o_rvalid,
    // Write address
    input  wire logic [`AXI_ID_W-1:0]                   i_awid,
    input  wire logic [`SRAM_ADDR_W-`SRAM_WORD_LSB-1:0] i_awaddr,
    input  wire logic [`AXI_LEN_W-1:0]                  i_awlen,
    input  wire logic [1:0]                             i_awburst,
    input  wire logic                                   i_awvalid,
    output logic                                        o_awready,
    // Write data and response
    input  wire logic                                   i_wlast,
    input  wire logic                                   i_wvalid,
    output logic                                        o_wready,
    input  wire logic                                   i_bready,
    output logic [`AXI_ID_W-1:0]                        o_bid,
    output logic [1:0]                                  o_bresp,
    output logic                                        o_bvalid,
    // Memory and burst control
    output logic                                        o_mem_we,
    burst_if.ctrl                                       bus
);

    sram_axi_pkg::state_e  state_q;
    sram_axi_pkg::state_e  state_d;
    logic [`AXI_ID_W-1:0]  id_q;
    logic                  wlast_err_q;
    logic                  ar_hs;
    logic                  aw_hs;
    logic                  r_hs;
    logic                  w_hs;
    logic                  b_hs;

    // ======================================
    // Handshakes
    // ======================================
    assign o_arready = (state_q == sram_axi_pkg::IDLE);
    // Read wins when both address channels are valid
    assign o_awready = (state_q == sram_axi_pkg::IDLE) && !i_arvalid;
    assign o_rvalid  = (state_q == sram_axi_pkg::RD_DATA);
    assign o_wready  = (state_q == sram_axi_pkg::WR_DATA);
    assign o_bvalid  = (state_q == sram_axi_pkg::WR_RESP);

    assign ar_hs = i_arvalid && o_arready;
    assign aw_hs = i_awvalid && o_awready;
    assign r_hs  = o_rvalid && i_rready;
    assign w_hs  = i_wvalid && o_wready;
    assign b_hs  = o_bvalid && i_bready;

    // ======================================
    // Burst control and responses
    // ======================================
    assign bus.load       = ar_hs || aw_hs;
    assign bus.start_addr = ar_hs ? i_araddr : i_awaddr;
    assign bus.len        = ar_hs ? i_arlen : i_awlen;
    assign bus.burst      = ar_hs ? sram_axi_pkg::burst_e'(i_arburst)
                                  : sram_axi_pkg::burst_e'(i_awburst);
    assign bus.step       = r_hs || w_hs;
    assign o_mem_we       = w_hs;

    assign o_rid   = id_q;
    assign o_bid   = id_q;
    assign o_rresp = sram_axi_pkg::OKAY;
    assign o_rlast = bus.last;
    assign o_bresp = wlast_err_q ? sram_axi_pkg::SLVERR : sram_axi_pkg::OKAY;

    always_comb begin
        state_d = state_q;
        case (state_q)
            sram_axi_pkg::IDLE: begin
                if (ar_hs) begin
                    state_d = sram_axi_pkg::RD_DATA;
                end
                else if (aw_hs) begin
                    state_d = sram_axi_pkg::WR_DATA;
                end
            end
            sram_axi_pkg::RD_DATA: begin
                if (r_hs && bus.last) begin
                    state_d = sram_axi_pkg::IDLE;
                end
            end
            sram_axi_pkg::WR_DATA: begin
                if (w_hs && bus.last) begin
                    state_d = sram_axi_pkg::WR_RESP;
                end
            end
            default: begin
                if (b_hs) begin
                    state_d = sram_axi_pkg::IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            state_q     <= sram_axi_pkg::IDLE;
            wlast_err_q <= 1'b0;
        end
        else begin
            state_q <= state_d;
            if (aw_hs) begin
                wlast_err_q <= 1'b0;
            end
            else if (w_hs && (i_wlast != bus.last)) begin
                wlast_err_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (ar_hs) begin
            id_q <= i_arid;
        end
        else if (aw_hs) begin
            id_q <= i_awid;
        end
    end

    // Valid holds until the master takes it
    assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        o_rvalid && !i_rready |=> o_rvalid);
    assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        o_bvalid && !i_bready |=> o_bvalid);

endmodule

`default_nettype wire

// File: rtl/burst_addr_gen.sv
`default_nettype none
`include "sram_axi_config.svh"

module burst_addr_gen (
    input  wire logic i_aclk,
    input  wire logic i_areset_n,
    burst_if.gen      bus
);

    localparam int WORD_W = `SRAM_ADDR_W - `SRAM_WORD_LSB;

    logic [WORD_W-1:0]     addr_q;
    logic [`AXI_LEN_W-1:0] beat_cnt;
    logic [`AXI_LEN_W-1:0] len_q;
    sram_axi_pkg::burst_e  burst_q;
    logic [WORD_W-1:0]     addr_inc;
    logic [WORD_W-1:0]     wrap_mask;
    logic [WORD_W-1:0]     addr_next;

    // Increment wraps at the top of memory
    assign addr_inc  = addr_q + 1'b1;
    // Wrap window of len+1 words is a power of two
    assign wrap_mask = WORD_W'(len_q);

    always_comb begin
        case (burst_q)
            sram_axi_pkg::FIXED: addr_next = addr_q;
            sram_axi_pkg::WRAP:  addr_next = (addr_q & ~wrap_mask) | (addr_inc & wrap_mask);
            default:             addr_next = addr_inc;
        endcase
    end

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            addr_q   <= '0;
            beat_cnt <= '0;
            len_q    <= '0;
            burst_q  <= sram_axi_pkg::FIXED;
        end
        else if (bus.load) begin
            addr_q   <= bus.start_addr;
            beat_cnt <= '0;
            len_q    <= bus.len;
            burst_q  <= bus.burst;
        end
        else if (bus.step) begin
            addr_q   <= addr_next;
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign bus.addr = addr_q;
    assign bus.last = (beat_cnt == len_q);

    // Wrap bursts are 2, 4, 8 or 16 beats
    assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        bus.load && (bus.burst == sram_axi_pkg::WRAP) |->
            (bus.len != 0) && (bus.len < `SRAM_MAX_BEATS) &&
            (((bus.len + 1'b1) & bus.len) == 0));

endmodule

`default_nettype wire

// File: rtl/sram_bank.sv
`default_nettype none
`include "sram_axi_config.svh"

module sram_bank (
    input  wire logic                                   i_aclk,
    input  wire logic                                   i_areset_n,
    input  wire logic                                   i_we,
    input  wire logic [`SRAM_ADDR_W-`SRAM_WORD_LSB-1:0] i_addr,
    input  wire logic [`SRAM_DATA_W-1:0]                i_wdata,
    input  wire logic [`SRAM_STRB_W-1:0]                i_wstrb,
    output logic [`SRAM_DATA_W-1:0]                     o_rdata
);

    logic [`SRAM_DATA_W-1:0] mem [`SRAM_DEPTH];

    // Reset loads each word with its own index
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            for (int i = 0; i < `SRAM_DEPTH; i++) begin
                mem[i] <= `SRAM_DATA_W'(i);
            end
        end
        else if (i_we) begin
            for (int b = 0; b < `SRAM_STRB_W; b++) begin
                if (i_wstrb[b]) begin
                    mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Asynchronous read
    assign o_rdata = mem[i_addr];

    assert property (@(posedge i_aclk) disable iff (!i_areset_n)
        !$isunknown(i_we));

endmodule

`default_nettype wire

// File: rtl/sram_axi_top.sv
`default_nettype none
`include "sram_axi_config.svh"

module sram_axi_top (
    input  wire logic                      i_aclk,
    input  wire logic                      i_areset_n,
    // Read address
    input  wire logic [`AXI_ID_W-1:0]      i_arid,
    input  wire logic [`SRAM_ADDR_W-1:0]   i_araddr,
    input  wire logic [`AXI_LEN_W-1:0]     i_arlen,
    input  wire logic [1:0]                i_arburst,
    input  wire logic                      i_arvalid,
    output logic                           o_arready,
    // Read data
    input  wire logic                      i_rready,
    output logic [`AXI_ID_W-1:0]           o_rid,
    output logic [`SRAM_DATA_W-1:0]        o_rdata,
    output logic [1:0]                     o_rresp,
    output logic                           o_rlast,
    output logic                           o_rvalid,
    // Write address
    input  wire logic [`AXI_ID_W-1:0]      i_awid,
    input  wire logic [`SRAM_ADDR_W-1:0]   i_awaddr,
    input  wire logic [`AXI_LEN_W-1:0]     i_awlen,
    input  wire logic [1:0]                i_awburst,
    input  wire logic                      i_awvalid,
    output logic                           o_awready,
    // Write data
    input  wire logic [`SRAM_DATA_W-1:0]   i_wdata,
    input  wire logic [`SRAM_STRB_W-1:0]   i_wstrb,
    input  wire logic                      i_wlast,
    input  wire logic                      i_wvalid,
    output logic                           o_wready,
    // Write response
    input  wire logic                      i_bready,
    output logic [`AXI_ID_W-1:0]           o_bid,
    output logic [1:0]                     o_bresp,
    output logic                           o_bvalid
);

    logic mem_we;

    burst_if u_bus ();

    // Byte offset bits are dropped from both address channels
    axi_slave_fsm u_fsm (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_arid     (i_arid),
        .i_araddr   (i_araddr[`SRAM_ADDR_W-1:`SRAM_WORD_LSB]),
        .i_arlen    (i_arlen),
        .i_arburst  (i_arburst),
        .i_arvalid  (i_arvalid),
        .o_arready  (o_arready),
        .i_rready   (i_rready),
        .o_rid      (o_rid),
        .o_rresp    (o_rresp),
        .o_rlast    (o_rlast),
        .o_rvalid   (o_rvalid),
        .i_awid     (i_awid),
        .i_awaddr   (i_awaddr[`SRAM_ADDR_W-1:`SRAM_WORD_LSB]),
        .i_awlen    (i_awlen),
        .i_awburst  (i_awburst),
        .i_awvalid  (i_awvalid),
        .o_awready  (o_awready),
        .i_wlast    (i_wlast),
        .i_wvalid   (i_wvalid),
        .o_wready   (o_wready),
        .i_bready   (i_bready),
        .o_bid      (o_bid),
        .o_bresp    (o_bresp),
        .o_bvalid   (o_bvalid),
        .o_mem_we   (mem_we),
        .bus        (u_bus)
    );

    burst_addr_gen u_gen (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .bus        (u_bus)
    );

    sram_bank u_bank (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_we       (mem_we),
        .i_addr     (u_bus.addr),
        .i_wdata    (i_wdata),
        .i_wstrb    (i_wstrb),
        .o_rdata    (o_rdata)
    );

endmodule

`default_nettype wire

// File: bench/clk_rst_gen.sv
`default_nettype none

module clk_rst_gen (
    output logic o_aclk,
    output logic o_areset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        o_aclk = 1'b0;
        forever #HALF_PERIOD o_aclk = ~o_aclk;
    end

    // Released on a rising edge
    initial begin
        o_areset_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge o_aclk);
        o_areset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/tb_sram_axi.sv
`default_nettype none
`include "sram_axi_config.svh"

module tb_sram_axi;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TRANS = 200;
    // 200 bursts of up to 16 beats at about 4 cycles a beat plus overhead
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int WORD_W = `SRAM_ADDR_W - `SRAM_WORD_LSB;

    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_WRAP  = 2'd2;
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    logic aclk;
    logic areset_n;
    logic [`AXI_ID_W-1:0]    arid, rid, awid, bid;
    logic [`SRAM_ADDR_W-1:0] araddr, awaddr;
    logic [`AXI_LEN_W-1:0]   arlen, awlen;
    logic [1:0]              arburst, awburst, rresp, bresp;
    logic [`SRAM_DATA_W-1:0] rdata, wdata;
    logic [`SRAM_STRB_W-1:0] wstrb;
    logic arvalid, arready, rready, rlast, rvalid, awvalid, awready;
    logic wlast, wvalid, wready, bready, bvalid;

    logic [`SRAM_DATA_W-1:0] model_mem [`SRAM_DEPTH];
    integer seed = 32'h88887740;
    int     cycle_cnt = 0;

    clk_rst_gen u_clk (.o_aclk(aclk), .o_areset_n(areset_n));

    sram_axi_top DUT (
        .i_aclk(aclk), .i_areset_n(areset_n),
        .i_arid(arid), .i_araddr(araddr), .i_arlen(arlen), .i_arburst(arburst),
        .i_arvalid(arvalid), .o_arready(arready),
        .i_rready(rready), .o_rid(rid), .o_rdata(rdata), .o_rresp(rresp),
        .o_rlast(rlast), .o_rvalid(rvalid),
        .i_awid(awid), .i_awaddr(awaddr), .i_awlen(awlen), .i_awburst(awburst),
        .i_awvalid(awvalid), .o_awready(awready),
        .i_wdata(wdata), .i_wstrb(wstrb), .i_wlast(wlast), .i_wvalid(wvalid),
        .o_wready(wready),
        .i_bready(bready), .o_bid(bid), .o_bresp(bresp), .o_bvalid(bvalid)
    );

    // ========================================
    // Helpers and reference model
    // ========================================
    function automatic int draw_random();
        return $random(seed);
    endfunction

    // High about three cycles out of four
    function automatic logic draw_ready();
        return (draw_random() & 3) != 0;
    endfunction

    function automatic logic [WORD_W-1:0] next_word(input logic [WORD_W-1:0] word,
                                                    input logic [1:0] burst, input int len);
        int beats;
        int base;
        int nxt;
        beats = len + 1;
        base  = int'(word) - (int'(word) % beats);
        if (burst == BURST_FIXED) begin
            nxt = int'(word);
        end
        else if (burst == BURST_WRAP) begin
            nxt = base + ((int'(word) - base + 1) % beats);
        end
        else begin
            nxt = (int'(word) + 1) % `SRAM_DEPTH;
        end
        return WORD_W'(nxt);
    endfunction

    function automatic logic [63:0] strobe_mask(input logic [7:0] strb);
        logic [63:0] mask;
        for (int b = 0; b < 8; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return mask;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ========================================
    // Transactions
    // ========================================
    task automatic run_read(input logic [3:0] id, input logic [10:0] addr, input int len,
                            input logic [1:0] burst);
        logic [WORD_W-1:0] word;
        int beat;
        word = addr[`SRAM_ADDR_W-1:`SRAM_WORD_LSB];
        beat = 0;
        arid    <= id;
        araddr  <= addr;
        arlen   <= `AXI_LEN_W'(len);
        arburst <= burst;
        arvalid <= 1'b1;
        @(posedge aclk);
        // Idle slave takes the read at once and holds off the write channel
        check_value(64'(arready), 64'd1, "ARREADY in idle");
        check_value(64'(awready), 64'd0, "AWREADY while ARVALID is high");
        arvalid <= 1'b0;
        rready  <= draw_ready();
        // Checked on every valid cycle so stalls must hold the beat
        while (beat <= len) begin
            @(posedge aclk);
            check_value(64'(rvalid), 64'd1, "RVALID during read burst");
            check_value(64'(arready), 64'd0, "ARREADY during read burst");
            check_value(rdata, model_mem[word], "RDATA");
            check_value(64'(rlast), 64'(beat == len), "RLAST");
            check_value(64'(rid), 64'(id), "RID");
            check_value(64'(rresp), 64'(RESP_OKAY), "RRESP");
            if (rready) begin
                beat++;
                word = next_word(word, burst, len);
            end
            rready <= draw_ready();
        end
    endtask

    task automatic run_write(input logic [3:0] id, input logic [10:0] addr, input int len,
                             input logic [1:0] burst, input logic bad_wlast);
        logic [WORD_W-1:0] word;
        logic [63:0] data;
        logic [7:0]  strb;
        logic [1:0]  exp_resp;
        logic        done;
        int beat;
        int wlast_beat;
        word       = addr[`SRAM_ADDR_W-1:`SRAM_WORD_LSB];
        beat       = 0;
        done       = 1'b0;
        wlast_beat = len;
        exp_resp   = RESP_OKAY;
        if (bad_wlast) begin
            exp_resp = RESP_SLVERR;
            // Early WLAST or none at all on a single beat
            wlast_beat = (len == 0) ? 1 : int'($unsigned(draw_random()) % len);
        end
        awid    <= id;
        awaddr  <= addr;
        awlen   <= `AXI_LEN_W'(len);
        awburst <= burst;
        awvalid <= 1'b1;
        @(posedge aclk);
        check_value(64'(awready), 64'd1, "AWREADY in idle");
        awvalid <= 1'b0;
        data = {draw_random(), draw_random()};
        strb = 8'(draw_random());
        wdata  <= data;
        wstrb  <= strb;
        wlast  <= (beat == wlast_beat);
        wvalid <= draw_ready();
        while (beat <= len) begin
            @(posedge aclk);
            check_value(64'(wready), 64'd1, "WREADY during write burst");
            check_value(64'(awready), 64'd0, "AWREADY during write burst");
            check_value(64'(bvalid), 64'd0, "BVALID before final write beat");
            if (wvalid) begin
                model_mem[word] = (model_mem[word] & ~strobe_mask(strb)) |
                                  (data & strobe_mask(strb));
                beat++;
                word = next_word(word, burst, len);
                data = {draw_random(), draw_random()};
                strb = 8'(draw_random());
                wdata  <= data;
                wstrb  <= strb;
                wlast  <= (beat == wlast_beat);
                wvalid <= (beat <= len) && draw_ready();
            end
            else begin
                wvalid <= draw_ready();
            end
        end
        bready <= draw_ready();
        while (!done) begin
            @(posedge aclk);
            check_value(64'(bvalid), 64'd1, "BVALID after final write beat");
            check_value(64'(bid), 64'(id), "BID");
            check_value(64'(bresp), 64'(exp_resp), "BRESP");
            done = bready;
            bready <= draw_ready();
        end
    endtask

    // ========================================
    // Main sequence and timeout
    // ========================================
    initial begin
        logic [3:0]  id;
        logic [7:0]  word;
        logic [10:0] addr;
        logic [1:0]  burst;
        logic        bad;
        int len;
        int rnd;
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            model_mem[i] = 64'(i);
        end
        arid    <= '0;
        araddr  <= '0;
        arlen   <= '0;
        arburst <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        bready  <= 1'b0;
        awid    <= '0;
        awaddr  <= '0;
        awlen   <= '0;
        awburst <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wlast   <= 1'b0;
        wvalid  <= 1'b0;
        wait (areset_n === 1'b1);
        @(posedge aclk);
        for (int t = 0; t < N_TRANS; t++) begin
            id    = 4'(draw_random());
            burst = 2'($unsigned(draw_random()) % 3);
            if (burst == BURST_WRAP) begin
                len = (2 << ($unsigned(draw_random()) % 4)) - 1;
            end
            else begin
                len = int'($unsigned(draw_random()) % 16);
            end
            rnd  = draw_random();
            word = rnd[7:0];
            // Start near the top now and then so INCR rolls over
            if ((rnd & 32'h700) == 0) begin
                word = 8'hf8 | {5'd0, rnd[2:0]};
            end
            addr = {word, rnd[15:13]};
            bad  = (draw_random() & 7) == 0;
            // Reads only at first to see the reset contents
            if (t >= 16 && (draw_random() & 1) != 0) begin
                run_write(id, addr, len, burst, bad);
            end
            else begin
                run_read(id, addr, len, burst);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/sram_axi_pkg.sv
rtl/burst_if.sv
rtl/axi_slave_fsm.sv
rtl/burst_addr_gen.sv
rtl/sram_bank.sv
rtl/sram_axi_top.sv
bench/clk_rst_gen.sv
bench/tb_sram_axi.sv

// File: Makefile
# Verilator simulation of the AXI4 SRAM slave

TOP := tb_sram_axi
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
